/* Makefile */
# Verilator build and run of the core testbench

TOP := tb_cpu

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* hdl/alu.sv */
// operand select, integer arithmetic and logic, registered result
`timescale 1ns/1ps

module alu (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alu_load,
    input  rv_isa_pkg::dec_t             dec,
    input  logic [rv_isa_pkg::xlen-1:0]  pc,
    input  logic [rv_isa_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]  rs2_data,
    output logic [rv_isa_pkg::xlen-1:0]  result,
    output logic                         zero
);
    import rv_isa_pkg::*;

    logic [xlen-1:0]  op_a;
    logic [xlen-1:0]  op_b;
    logic [4:0]       shamt;
    logic [xlen-1:0]  alu_out;

    assign op_a  = (dec.src_a == src_a_pc) ? pc : rs1_data;
    assign op_b  = (dec.src_b == src_b_imm) ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_sub:    alu_out = op_a - op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_or:     alu_out = op_a | op_b;
            alu_xor:    alu_out = op_a ^ op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
            alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {31'b0, op_a < op_b};
            alu_pass_b: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            result <= '0;
        end else if (alu_load) begin
            result <= alu_out;
        end
    end

    // beq and bne look at this in write-back
    assign zero = (result == '0);

endmodule

/* hdl/bus_pkg.sv */
// wishbone classic widths and the master request and slave response bundles
package bus_pkg;

    localparam int wb_addr_w = 32;
    localparam int wb_data_w = 32;

    // master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [wb_addr_w-1:0]  adr;
        logic [wb_data_w-1:0]  dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                  ack;
        logic [wb_data_w-1:0]  dat;
    } wb_rsp_t;

endpackage

/* hdl/core_fsm.sv */
// instruction-cycle sequencer, wishbone master and write-back select
`timescale 1ns/1ps

module core_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_isa_pkg::dec_t             dec,
    input  logic [rv_isa_pkg::xlen-1:0]  pc,
    input  logic [rv_isa_pkg::xlen-1:0]  link,
    input  logic [rv_isa_pkg::xlen-1:0]  alu_result,
    input  logic [rv_isa_pkg::xlen-1:0]  rs2_data,
    input  bus_pkg::wb_rsp_t             wb_rsp,
    output bus_pkg::wb_req_t             wb_req,
    output logic                         ir_load,
    output logic                         alu_load,
    output logic                         pc_load,
    output logic                         rf_we,
    output logic [rv_isa_pkg::xlen-1:0]  rf_wdata,
    output logic [rv_isa_pkg::xlen-1:0]  fetch_word
);
    import rv_isa_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback
    } state_e;

    state_e                 state;
    // cyc and stb always move together
    logic                   req_q;
    logic                   we_q;
    logic                   bus_done;
    logic [wb_data_w-1:0]   load_data;

    assign bus_done = req_q && wb_rsp.ack;

    // ---------------------------------------------------------
    // sequencer
    // ---------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_fetch;
            req_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (bus_done) begin
                        state <= st_decode;
                        req_q <= 1'b0;
                    end else begin
                        // only the first fetch after reset gets here idle
                        req_q <= 1'b1;
                    end
                end
                st_decode: begin
                    state <= st_execute;
                end
                st_execute: begin
                    if (dec.mem_op != mem_none) begin
                        state <= st_memory;
                        req_q <= 1'b1;
                        we_q  <= (dec.mem_op == mem_write);
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_memory: begin
                    if (bus_done) begin
                        state <= st_writeback;
                        req_q <= 1'b0;
                        we_q  <= 1'b0;
                    end
                end
                st_writeback: begin
                    // next fetch starts with the updated pc
                    state <= st_fetch;
                    req_q <= 1'b1;
                end
                default: begin
                    state <= st_fetch;
                    req_q <= 1'b0;
                    we_q  <= 1'b0;
                end
            endcase
        end
    end

    // read data captured on the load ack
    always_ff @(posedge clk) begin
        if (state == st_memory && bus_done && !we_q) begin
            load_data <= wb_rsp.dat;
        end
    end

    // ---------------------------------------------------------
    // strobes and bus
    // ---------------------------------------------------------
    assign ir_load    = (state == st_fetch) && bus_done;
    assign alu_load   = (state == st_execute);
    assign pc_load    = (state == st_writeback);
    assign rf_we      = pc_load && (dec.wb_src != wb_none);
    assign fetch_word = wb_rsp.dat;

    always_comb begin
        case (dec.wb_src)
            wb_load: rf_wdata = load_data;
            wb_link: rf_wdata = link;
            default: rf_wdata = alu_result;
        endcase
    end

    // address is the pc in fetch and the alu result in memory
    always_comb begin
        wb_req.cyc = req_q;
        wb_req.stb = req_q;
        wb_req.we  = we_q;
        wb_req.adr = (state == st_memory) ? alu_result : pc;
        wb_req.dat = rs2_data;
    end

endmodule

/* hdl/cpu_top.sv */
// multi-cycle rv32i subset core with one shared wishbone master port
`timescale 1ns/1ps

module cpu_top (
    input  logic             clk,
    input  logic             rst,
    output bus_pkg::wb_req_t wb_req,
    input  bus_pkg::wb_rsp_t wb_rsp
);
    import rv_isa_pkg::*;

    dec_t               dec;
    logic               ir_load;
    logic               alu_load;
    logic               pc_load;
    logic               rf_we;
    logic [xlen-1:0]    rf_wdata;
    logic [xlen-1:0]    fetch_word;
    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    link;
    logic [xlen-1:0]    rs1_data;
    logic [xlen-1:0]    rs2_data;
    logic [xlen-1:0]    alu_result;
    logic               alu_zero;

    // ---------------------------------------------------------
    // control
    // ---------------------------------------------------------
    core_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .pc         (pc),
        .link       (link),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .wb_rsp     (wb_rsp),
        .wb_req     (wb_req),
        .ir_load    (ir_load),
        .alu_load   (alu_load),
        .pc_load    (pc_load),
        .rf_we      (rf_we),
        .rf_wdata   (rf_wdata),
        .fetch_word (fetch_word)
    );

    inst_decoder u_dec (
        .clk        (clk),
        .rst        (rst),
        .ir_load    (ir_load),
        .fetch_word (fetch_word),
        .dec        (dec)
    );

    // ---------------------------------------------------------
    // datapath
    // ---------------------------------------------------------
    pc_unit u_pc (
        .clk      (clk),
        .rst      (rst),
        .pc_load  (pc_load),
        .dec      (dec),
        .rs1_data (rs1_data),
        .alu_zero (alu_zero),
        .pc       (pc),
        .link     (link)
    );

    reg_file u_rf (
        .clk      (clk),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd       (dec.rd),
        .we       (rf_we),
        .wdata    (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .alu_load (alu_load),
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result),
        .zero     (alu_zero)
    );

endmodule

/* hdl/inst_decoder.sv */
// instruction register, field decode and immediate generation
`timescale 1ns/1ps

module inst_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ir_load,
    input  logic [rv_isa_pkg::xlen-1:0]  fetch_word,
    output rv_isa_pkg::dec_t             dec
);
    import rv_isa_pkg::*;

    logic [xlen-1:0]  ir;
    opcode_e          opc;
    logic [2:0]       funct3;
    logic             f7b5;
    logic [xlen-1:0]  imm_i;
    logic [xlen-1:0]  imm_s;
    logic [xlen-1:0]  imm_b;
    logic [xlen-1:0]  imm_u;
    logic [xlen-1:0]  imm_j;

    // funct7 bit 5 picks sra in both forms and sub only in register ops
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic b5,
                                               input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && b5) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return b5 ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            ir <= nop_insn;
        end else if (ir_load) begin
            ir <= fetch_word;
        end
    end

    assign opc    = opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign f7b5   = ir[30];

    // immediate formats
    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        dec = '{alu_op: alu_add, src_a: src_a_reg, src_b: src_b_imm, branch: br_none,
                wb_src: wb_none, mem_op: mem_none, rd: ir[11:7], rs1: ir[19:15],
                rs2: ir[24:20], imm: imm_i};
        case (opc)
            opc_op: begin
                dec.alu_op = alu_from_funct(funct3, f7b5, 1'b1);
                dec.src_b  = src_b_reg;
                dec.wb_src = wb_alu;
            end
            opc_op_imm: begin
                dec.alu_op = alu_from_funct(funct3, f7b5, 1'b0);
                dec.wb_src = wb_alu;
            end
            opc_lui: begin
                dec.alu_op = alu_pass_b;
                dec.imm    = imm_u;
                dec.wb_src = wb_alu;
            end
            opc_auipc: begin
                dec.src_a  = src_a_pc;
                dec.imm    = imm_u;
                dec.wb_src = wb_alu;
            end
            opc_jal: begin
                dec.branch = br_jal;
                dec.imm    = imm_j;
                dec.wb_src = wb_link;
            end
            opc_jalr: begin
                dec.branch = br_jalr;
                dec.wb_src = wb_link;
            end
            opc_branch: begin
                dec.alu_op = alu_sub;
                dec.src_b  = src_b_reg;
                dec.imm    = imm_b;
                if (funct3 == 3'b000) begin
                    dec.branch = br_eq;
                end else if (funct3 == 3'b001) begin
                    dec.branch = br_ne;
                end else begin
                    dec = dec_nop;
                end
            end
            opc_load: begin
                // word only
                dec.mem_op = mem_read;
                dec.wb_src = wb_load;
                if (funct3 != 3'b010) begin
                    dec = dec_nop;
                end
            end
            opc_store: begin
                dec.mem_op = mem_write;
                dec.imm    = imm_s;
                if (funct3 != 3'b010) begin
                    dec = dec_nop;
                end
            end
            default: dec = dec_nop;
        endcase
    end

endmodule

/* hdl/pc_unit.sv */
// program counter with branch decision, next-address select and link value
`timescale 1ns/1ps

module pc_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pc_load,
    input  rv_isa_pkg::dec_t             dec,
    input  logic [rv_isa_pkg::xlen-1:0]  rs1_data,
    input  logic                         alu_zero,
    output logic [rv_isa_pkg::xlen-1:0]  pc,
    output logic [rv_isa_pkg::xlen-1:0]  link
);
    import rv_isa_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] reg_target;
    logic [xlen-1:0] next_pc;

    assign pc_plus4   = pc + 32'd4;
    assign pc_target  = pc + dec.imm;
    assign reg_target = (rs1_data + dec.imm) & ~32'd1;
    assign link       = pc_plus4;

    // zero comes from the sub done in execute
    always_comb begin
        case (dec.branch)
            br_jal:  next_pc = pc_target;
            br_jalr: next_pc = reg_target;
            br_eq:   next_pc = alu_zero ? pc_target : pc_plus4;
            br_ne:   next_pc = alu_zero ? pc_plus4 : pc_target;
            default: next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

endmodule

/* hdl/reg_file.sv */
// 32 x 32 register file with two combinational reads, one write and x0 hardwired
`timescale 1ns/1ps

module reg_file (
    input  logic                               clk,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs1,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  rs2,
    input  logic [rv_isa_pkg::reg_addr_w-1:0]  rd,
    input  logic                               we,
    input  logic [rv_isa_pkg::xlen-1:0]        wdata,
    output logic [rv_isa_pkg::xlen-1:0]        rs1_data,
    output logic [rv_isa_pkg::xlen-1:0]        rs2_data
);
    import rv_isa_pkg::*;

    localparam int depth = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [depth];

    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hdl/rv_isa_pkg.sv */
// rv32i subset opcodes, control enums and the decoded instruction
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_insn = 32'h0000_0013;

    // major opcodes of the kept instruction set
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_e;

    typedef enum logic {src_a_reg, src_a_pc} src_a_e;
    typedef enum logic {src_b_reg, src_b_imm} src_b_e;

    // the two conditional branches and the two jumps
    typedef enum logic [2:0] {br_none, br_eq, br_ne, br_jal, br_jalr} branch_e;

    typedef enum logic [1:0] {wb_none, wb_alu, wb_load, wb_link} wb_src_e;

    typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_op_e;

    typedef struct packed {
        alu_op_e                alu_op;
        src_a_e                 src_a;
        src_b_e                 src_b;
        branch_e                branch;
        wb_src_e                wb_src;
        mem_op_e                mem_op;
        logic [reg_addr_w-1:0]  rd;
        logic [reg_addr_w-1:0]  rs1;
        logic [reg_addr_w-1:0]  rs2;
        logic [xlen-1:0]        imm;
    } dec_t;

    // retires with no write and pc plus 4
    localparam dec_t dec_nop = '{
        alu_op: alu_add,
        src_a:  src_a_reg,
        src_b:  src_b_imm,
        branch: br_none,
        wb_src: wb_none,
        mem_op: mem_none,
        rd:     '0,
        rs1:    '0,
        rs2:    '0,
        imm:    '0
    };

endpackage

/* src.f */
hdl/rv_isa_pkg.sv
hdl/bus_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/inst_decoder.sv
hdl/pc_unit.sv
hdl/core_fsm.sv
hdl/cpu_top.sv
test/wb_memory.sv
test/tb_cpu.sv

/* test/tb_cpu.sv */
// testbench for the multi-cycle core that assembles programs and checks stores and bus timing
`timescale 1ns/1ps

module tb_cpu;
    import rv_isa_pkg::*;
    import bus_pkg::*;

    localparam logic [31:0] res_base   = 32'h0000_1000;
    localparam logic [31:0] res_end    = 32'h0000_1400;
    localparam logic [31:0] taken_mark = 32'h7a4e_11c3;
    localparam logic [31:0] fall_mark  = 32'h0f5d_2b96;
    localparam int          run_limit  = 20000;

    logic         clk;
    logic         rst;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    logic [31:0]  rand_state;
    int           emit_idx;
    int           slot;
    logic [31:0]  expected [$];
    int           write_count;
    logic [31:0]  end_addr;
    logic         end_seen;
    logic         first_seen;
    logic         held_valid;
    wb_req_t      held;

    cpu_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    wb_memory u_mem (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #4 clk = ~clk;

    // ----------------------------------------------------------
    // random numbers, reference model, reporting
    // ----------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state ^ (rand_state >> 16);
    endfunction

    // f3 and funct7 bit 5 select the operation as in RV32I
    function automatic logic [31:0] int_op_value(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [4:0]         sh;
        sa = a;
        sb = b;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return (sa < sb) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return sa >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        return (f3 == 3'b000) ? (a == b) : (a != b);
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    // ----------------------------------------------------------
    // instruction encoders and program builder
    // ----------------------------------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    function automatic logic [31:0] cur_pc();
        return 32'(emit_idx) << 2;
    endfunction

    task automatic emit(input logic [31:0] insn);
        u_mem.mem[emit_idx] = insn;
        emit_idx++;
    endtask

    // lui plus addi with the upper part rounded for the signed low part
    task automatic emit_li(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h800;
        emit(enc_u(upper[31:12], rd, opc_lui));
        emit(enc_i(v[11:0], rd, 3'b000, rd, opc_op_imm));
    endtask

    task automatic store_expect(input logic [4:0] rs, input logic [31:0] value);
        emit(enc_s(12'(slot * 4), rs, 5'd1));
        expected.push_back(value);
        slot++;
    endtask

    // one marker word for the path taken lands in the slot
    task automatic emit_branch_case(input logic [2:0] f3, input logic [4:0] rs2,
                                    input logic [31:0] va, input logic [31:0] vb);
        emit(enc_b(13'd12, rs2, 5'd2, f3));
        emit(enc_s(12'(slot * 4), 5'd9, 5'd1));
        emit(enc_j(21'd8, 5'd0));
        store_expect(5'd8, branch_taken(f3, va, vb) ? taken_mark : fall_mark);
    endtask

    task automatic build_program();
        logic [2:0]   r_f3  [10];
        logic         r_alt [10];
        logic [2:0]   i_f3  [9];
        logic         i_alt [9];
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  r;
        logic [31:0]  here;
        logic [11:0]  imm;
        r_f3  = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5, 3'd5, 3'd2, 3'd3};
        r_alt = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        i_f3  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        i_alt = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        for (int i = 0; i < 2048; i++) begin
            u_mem.mem[i] = {~16'(i), 16'(i)};
        end
        expected.delete();
        emit_idx = 0;
        slot     = 0;
        // x1 points at the result area
        emit(enc_u(20'h00001, 5'd1, opc_lui));
        for (int k = 0; k < 10; k++) begin
            a = next_rand();
            b = next_rand();
            emit_li(5'd2, a);
            emit_li(5'd3, b);
            emit(enc_r({1'b0, r_alt[k], 5'b0}, 5'd3, 5'd2, r_f3[k], 5'd4));
            store_expect(5'd4, int_op_value(r_f3[k], r_alt[k], a, b));
        end
        for (int k = 0; k < 9; k++) begin
            a = next_rand();
            r = next_rand();
            imm = r[31:20];
            if (i_f3[k] == 3'd1 || i_f3[k] == 3'd5) begin
                imm = {1'b0, i_alt[k], 5'b0, r[31:27]};
            end
            emit_li(5'd2, a);
            emit(enc_i(imm, 5'd2, i_f3[k], 5'd4, opc_op_imm));
            store_expect(5'd4, int_op_value(i_f3[k], i_alt[k], a, {{20{imm[11]}}, imm}));
        end
        r = next_rand();
        emit(enc_u(r[19:0], 5'd4, opc_lui));
        store_expect(5'd4, {r[19:0], 12'b0});
        r = next_rand();
        here = cur_pc();
        emit(enc_u(r[19:0], 5'd4, opc_auipc));
        store_expect(5'd4, here + {r[19:0], 12'b0});
        // store, reload from scratch at 0x1400 and store again
        for (int k = 0; k < 3; k++) begin
            a = next_rand();
            emit_li(5'd5, a);
            emit(enc_s(12'h400 + 12'(4 * k), 5'd5, 5'd1));
            emit(enc_i(12'h400 + 12'(4 * k), 5'd1, 3'b010, 5'd6, opc_load));
            store_expect(5'd6, a);
        end
        emit(enc_i(12'h400, 5'd1, 3'b010, 5'd0, opc_load));
        store_expect(5'd0, 32'h0);
        emit(enc_i(12'h04d, 5'd2, 3'b000, 5'd0, opc_op_imm));
        store_expect(5'd0, 32'h0);
        emit_li(5'd8, taken_mark);
        emit_li(5'd9, fall_mark);
        a = next_rand();
        b = a ^ (next_rand() | 32'h1);
        emit_li(5'd2, a);
        emit_li(5'd3, a);
        emit_li(5'd7, b);
        emit_branch_case(3'b000, 5'd3, a, a);
        emit_branch_case(3'b000, 5'd7, a, b);
        emit_branch_case(3'b001, 5'd3, a, a);
        emit_branch_case(3'b001, 5'd7, a, b);
        // jal over one store
        here = cur_pc();
        emit(enc_j(21'd8, 5'd10));
        emit(enc_s(12'(slot * 4), 5'd9, 5'd1));
        store_expect(5'd10, here + 32'd4);
        // jalr to auipc base plus 13 with bit 0 dropped
        here = cur_pc();
        emit(enc_u(20'h0, 5'd11, opc_auipc));
        emit(enc_i(12'd13, 5'd11, 3'b000, 5'd12, opc_jalr));
        emit(enc_s(12'(slot * 4), 5'd9, 5'd1));
        store_expect(5'd12, here + 32'd8);
        end_addr = cur_pc();
        emit(enc_j(21'd0, 5'd0));
    endtask

    // ----------------------------------------------------------
    // bus monitor and result compare
    // ----------------------------------------------------------
    task automatic record_access();
        if (wb_req.we && wb_req.adr >= res_base && wb_req.adr < res_end) begin
            if (write_count >= expected.size()) begin
                stop_on_failure("the core wrote more results than the program holds");
            end
            check_value($sformatf("result %0d address", write_count), wb_req.adr,
                        res_base + 32'(write_count * 4));
            check_value($sformatf("result %0d data", write_count), wb_req.dat,
                        expected[write_count]);
            write_count++;
        end
        if (!wb_req.we && wb_req.adr == end_addr) begin
            end_seen = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            held_valid  = 1'b0;
            first_seen  = 1'b0;
            end_seen    = 1'b0;
            write_count = 0;
        end else begin
            // cyc and stb rise and fall together
            check_value("cyc against stb", 32'(wb_req.cyc), 32'(wb_req.stb));
            if (wb_req.cyc && wb_req.stb) begin
                if (!first_seen) begin
                    check_value("first request address", wb_req.adr, 32'h0);
                    check_value("first request we", 32'(wb_req.we), 32'h0);
                    first_seen = 1'b1;
                end
                // request must not move while waiting for ack
                if (held_valid) begin
                    check_value("held adr", wb_req.adr, held.adr);
                    check_value("held we", 32'(wb_req.we), 32'(held.we));
                    if (held.we) begin
                        check_value("held dat", wb_req.dat, held.dat);
                    end
                end
                held       = wb_req;
                held_valid = !wb_rsp.ack;
                if (wb_rsp.ack) begin
                    record_access();
                end
            end else if (held_valid) begin
                stop_on_failure("the core dropped a bus request before its ack");
            end
        end
    end

    task automatic run_program();
        int cycles;
        @(posedge clk);
        #1;
        rst = 1'b0;
        build_program();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        cycles = 0;
        while (!end_seen && cycles < run_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!end_seen) begin
            stop_on_failure($sformatf("timeout: program end not fetched, %0d of %0d results",
                                      write_count, expected.size()));
        end
        check_value("result write count", 32'(write_count), 32'(expected.size()));
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        rand_state = 32'd31186;
        for (int round = 0; round < 2; round++) begin
            run_program();
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* test/wb_memory.sv */
// wishbone classic slave memory model with a random ack delay per access
`timescale 1ns/1ps

module wb_memory (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t wb_req,
    output bus_pkg::wb_rsp_t wb_rsp
);
    import bus_pkg::*;

    // 8 KB of words addressed by adr[12:2]
    logic [wb_data_w-1:0]  mem [0:2047];
    logic [31:0]           lcg_state = 32'd31186;
    logic [1:0]            wait_cnt;
    logic                  ack_q;
    logic [wb_data_w-1:0]  rdata_q = '0;
    wb_rsp_t               rsp_q = '0;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            ack_q    <= 1'b0;
            wait_cnt <= 2'd0;
        end else begin
            ack_q <= 1'b0;
            // no second ack in the cycle right after one
            if (wb_req.cyc && wb_req.stb && !ack_q) begin
                if (wait_cnt == 2'd0) begin
                    ack_q <= 1'b1;
                    if (wb_req.we) begin
                        mem[wb_req.adr[12:2]] = wb_req.dat;
                    end
                    rdata_q   <= mem[wb_req.adr[12:2]];
                    lcg_state <= lcg_step(lcg_state);
                    // delay of 0 to 3 extra cycles for the next access
                    wait_cnt  <= lcg_state[17:16];
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

    // response changes shortly after the edge
    always @(posedge clk) begin
        #1;
        rsp_q.ack = ack_q;
        rsp_q.dat = rdata_q;
    end

    assign wb_rsp = rsp_q;

endmodule
